// ==== design/mpu_bus_pkg.sv ====
package mpu_bus_pkg;

	// ========================================================================
	// address map, matched against adr[31:8]
	// ========================================================================
	localparam logic [23:0] PIT_BASE = 24'hFFDC11;	// interval timer page
	localparam logic [23:0] PIC_BASE = 24'hFFDC0F;	// interrupt controller page

	// master request as issued by the cpu
	typedef struct packed {
		logic        cyc;	// bus cycle in progress
		logic        stb;
		logic        we;
		logic [2:0]  cti;	// cycle type id
		logic [1:0]  bte;	// burst type ext
		logic [7:0]  sel;	// byte lanes of the 64 bit word
		logic [31:0] adr;
		logic [63:0] dat;
	} bus_req_t;

	typedef struct packed {
		logic        ack;
		logic        err;
		logic [63:0] dat;
	} bus_rsp_t;

	// already decoded request for one internal slave
	typedef struct packed {
		logic        stb;	// cyc folded in
		logic        we;
		logic [3:0]  sel;	// upper and lower lanes or'ed together
		logic [7:0]  adr;	// offset within the slave page
		logic [31:0] dat;
	} periph_req_t;

	typedef struct packed {
		logic        ack;
		logic [31:0] dat;
	} periph_rsp_t;

	// byte lane merge for register writes
	function automatic logic [31:0] sel_merge(input logic [31:0] old_v,
		input logic [31:0] new_v, input logic [3:0] sel);
		logic [31:0] res;
		res = old_v;
		for (int b = 0; b < 4; b++) begin
			if (sel[b])
				res[b*8 +: 8] = new_v[b*8 +: 8];	// take this lane
		end
		return res;
	endfunction

endpackage

// ==== design/mpu_irq_pkg.sv ====
package mpu_irq_pkg;

	// ========================================================================
	// interrupt widths
	// ========================================================================
	localparam int NUM_SRC = 32;	// source 0 never fires
	localparam int CAUSE_W = 7;	// cause 0 means nothing pending
	localparam int IRQ_W   = 3;	// interrupt level to the cpu

	localparam int NUM_CH = 3;	// timer channels

	// timer channel modes, ctrl bits 2:1
	typedef enum logic [1:0] {
		PIT_ONESHOT  = 2'd0,	// single pulse then stop
		PIT_PERIODIC = 2'd1,	// pulse and reload
		PIT_SQUARE   = 2'd2	// toggle and reload
	} pit_mode_e;

	// ========================================================================
	// timer registers, offset inside a 16 byte channel window
	// ========================================================================
	localparam logic [3:0] PIT_RELOAD = 4'h0;
	localparam logic [3:0] PIT_COUNT  = 4'h4;	// read only
	localparam logic [3:0] PIT_CTRL   = 4'h8;
	localparam int         PIT_CTRL_EN = 0;	// enable bit in ctrl

	// ========================================================================
	// interrupt controller registers
	// ========================================================================
	localparam logic [7:0] PIC_ENABLE  = 8'h00;
	localparam logic [7:0] PIC_EDGE    = 8'h04;	// 1 = edge triggered
	localparam logic [7:0] PIC_PENDING = 8'h08;	// read only
	localparam logic [7:0] PIC_CLEAR   = 8'h0C;	// write source number
	localparam logic [7:0] PIC_LEVEL   = 8'h10;
	localparam logic [7:0] PIC_CAUSE   = 8'h14;

endpackage

// ==== design/mpu_periph_bus.sv ====
`timescale 1ns/1ps

module mpu_periph_bus (
	input  logic                     clk_i,
	input  logic                     rst_n_i,
	input  mpu_bus_pkg::bus_req_t    cpu_req_i,
	output mpu_bus_pkg::bus_rsp_t    cpu_rsp_o,
	output mpu_bus_pkg::periph_req_t pit_req_o,
	input  mpu_bus_pkg::periph_rsp_t pit_rsp_i,
	output mpu_bus_pkg::periph_req_t pic_req_o,
	input  mpu_bus_pkg::periph_rsp_t pic_rsp_i,
	output mpu_bus_pkg::bus_req_t    ext_req_o,
	input  mpu_bus_pkg::bus_rsp_t    ext_rsp_i
);
	import mpu_bus_pkg::*;

	logic        cs_pit;
	logic        cs_pic;
	logic        cs_ext;	// anything not mapped inside
	periph_req_t int_req;	// common lane to both internal slaves

	// ========================================================================
	// address decode
	// ========================================================================
	assign cs_pit = cpu_req_i.adr[31:8] == PIT_BASE;
	assign cs_pic = cpu_req_i.adr[31:8] == PIC_BASE;
	assign cs_ext = ~cs_pit & ~cs_pic;

	assign int_req.stb = cpu_req_i.cyc & cpu_req_i.stb;
	assign int_req.we  = cpu_req_i.we;
	assign int_req.sel = cpu_req_i.sel[7:4] | cpu_req_i.sel[3:0];	// fold lanes
	assign int_req.adr = cpu_req_i.adr[7:0];
	assign int_req.dat = cpu_req_i.dat[31:0];	// low lane only

	always_comb begin
		pit_req_o     = int_req;
		pit_req_o.stb = int_req.stb & cs_pit;
		pic_req_o     = int_req;
		pic_req_o.stb = int_req.stb & cs_pic;
	end

	// external pass through, strobes only when outside the internal pages
	always_comb begin
		ext_req_o     = cpu_req_i;
		ext_req_o.cyc = cpu_req_i.cyc & cs_ext;
		ext_req_o.stb = cpu_req_i.stb & cs_ext;
	end

	// ========================================================================
	// response merge
	// ========================================================================
	always_comb begin
		cpu_rsp_o.ack = pit_rsp_i.ack | pic_rsp_i.ack | ext_rsp_i.ack;
		cpu_rsp_o.err = ext_rsp_i.err;
		if (pit_rsp_i.ack)
			cpu_rsp_o.dat = {2{pit_rsp_i.dat}};	// both halves
		else if (pic_rsp_i.ack)
			cpu_rsp_o.dat = {2{pic_rsp_i.dat}};
		else
			cpu_rsp_o.dat = ext_rsp_i.dat;
	end

	// slaves never answer together
	a_one_ack: assert property (@(posedge clk_i) disable iff (!rst_n_i)
		$onehot0({pit_rsp_i.ack, pic_rsp_i.ack, ext_rsp_i.ack}));

	// every ack lands inside a master cycle
	a_ack_in_cyc: assert property (@(posedge clk_i) disable iff (!rst_n_i)
		cpu_rsp_o.ack |-> cpu_req_i.cyc);

endmodule

// ==== design/mpu_pic.sv ====
`timescale 1ns/1ps

module mpu_pic (
	input  logic                              clk_i,
	input  logic                              rst_n_i,
	input  mpu_bus_pkg::periph_req_t          req_i,
	output mpu_bus_pkg::periph_rsp_t          rsp_o,
	input  logic [mpu_irq_pkg::NUM_SRC-1:0]   src_i,
	output logic [mpu_irq_pkg::IRQ_W-1:0]     irq_o,	// level to the cpu
	output logic [mpu_irq_pkg::CAUSE_W-1:0]   cause_o
);
	import mpu_bus_pkg::*;
	import mpu_irq_pkg::*;

	logic [NUM_SRC-1:0] src_q;	// previous sample for edge detect
	logic [NUM_SRC-1:0] rise;
	logic [NUM_SRC-1:0] enable_q;
	logic [NUM_SRC-1:0] edge_q;
	logic [NUM_SRC-1:0] pending_q;
	logic [NUM_SRC-1:0] clr_mask;
	logic [NUM_SRC-1:0] active;
	logic [IRQ_W-1:0]   level_q;
	logic [CAUSE_W-1:0] top_src;
	logic               any_active;
	logic               wr_stb;
	logic               ack_q;
	logic [31:0]        dat_q;
	logic [31:0]        rd_dat;

	assign wr_stb = req_i.stb & req_i.we & ~ack_q;
	assign rise   = src_i & ~src_q;

	// one hot clear of the written source
	assign clr_mask = (wr_stb && req_i.adr == PIC_CLEAR) ?
		(NUM_SRC'(1) << req_i.dat[4:0]) : '0;

	// ========================================================================
	// source sampling and pending
	// ========================================================================
	always_ff @(posedge clk_i) begin
		if (!rst_n_i) begin
			src_q     <= '0;
			pending_q <= '0;
		end else begin
			src_q     <= src_i;
			// edge sources latch until cleared, level sources track input
			pending_q <= (edge_q & ((pending_q & ~clr_mask) | rise)) | (~edge_q & src_i);
		end
	end

	// register writes
	always_ff @(posedge clk_i) begin
		if (!rst_n_i) begin
			enable_q <= '0;
			edge_q   <= '0;
			level_q  <= '0;
		end else if (wr_stb) begin
			case (req_i.adr)
				PIC_ENABLE: enable_q <= sel_merge(enable_q, req_i.dat, req_i.sel);
				PIC_EDGE:   edge_q   <= sel_merge(edge_q, req_i.dat, req_i.sel);
				PIC_LEVEL: begin
					if (req_i.sel[0])
						level_q <= req_i.dat[IRQ_W-1:0];
				end
				default: ;	// pending and cause are read only
			endcase
		end
	end

	// ========================================================================
	// priority search, highest source number wins
	// ========================================================================
	assign active = pending_q & enable_q;

	always_comb begin
		top_src    = '0;
		any_active = 1'b0;
		for (int i = 1; i < NUM_SRC; i++) begin	// source 0 cannot report
			if (active[i]) begin
				top_src    = CAUSE_W'(i);
				any_active = 1'b1;
			end
		end
	end

	always_ff @(posedge clk_i) begin
		if (!rst_n_i) begin
			irq_o   <= '0;
			cause_o <= '0;
		end else begin
			irq_o   <= any_active ? level_q : '0;
			cause_o <= top_src;
		end
	end

	// ========================================================================
	// read mux and ack
	// ========================================================================
	always_comb begin
		case (req_i.adr)
			PIC_ENABLE:  rd_dat = enable_q;
			PIC_EDGE:    rd_dat = edge_q;
			PIC_PENDING: rd_dat = pending_q;
			PIC_LEVEL:   rd_dat = 32'(level_q);
			PIC_CAUSE:   rd_dat = 32'(cause_o);
			default:     rd_dat = '0;	// clear reads as zero
		endcase
	end

	always_ff @(posedge clk_i) begin
		if (!rst_n_i)
			ack_q <= 1'b0;
		else
			ack_q <= req_i.stb & ~ack_q;
	end

	always_ff @(posedge clk_i)
		dat_q <= rd_dat;

	assign rsp_o.ack = ack_q;
	assign rsp_o.dat = dat_q;

	// irq and cause come from the same search one clock back
	a_cause_irq: assert property (@(posedge clk_i) disable iff (!rst_n_i)
		($past(level_q) != '0) |-> ((cause_o != '0) == (irq_o != '0)));

endmodule

// ==== design/mpu_pit.sv ====
`timescale 1ns/1ps

module mpu_pit (
	input  logic                            clk_i,
	input  logic                            rst_n_i,
	input  mpu_bus_pkg::periph_req_t        req_i,
	output mpu_bus_pkg::periph_rsp_t        rsp_o,
	input  logic                            clk2_i,	// external clock, channel 2
	input  logic                            gate2_i,
	output logic [mpu_irq_pkg::NUM_CH-1:0]  out_o
);
	import mpu_bus_pkg::*;
	import mpu_irq_pkg::*;

	logic [31:0]       reload_q [NUM_CH];
	logic [31:0]       count_q [NUM_CH];
	pit_mode_e         mode_q [NUM_CH];
	logic [NUM_CH-1:0] en_q;
	logic [NUM_CH-1:0] ld_q;	// load count on next clock
	logic [NUM_CH-1:0] armed_q;	// cleared once a oneshot has fired
	logic [NUM_CH-1:0] tick;
	logic [NUM_CH-1:0] fire;	// count at zero on a tick

	logic [2:0]  clk2_sync_q;	// two sync flops plus edge history
	logic [1:0]  gate2_sync_q;
	logic [1:0]  ch;
	logic [3:0]  ofs;
	logic        ch_ok;
	logic        wr_stb;
	logic        ack_q;
	logic [31:0] dat_q;
	logic [31:0] rd_dat;

	// ========================================================================
	// channel 2 external clock and gate
	// ========================================================================
	always_ff @(posedge clk_i) begin
		if (!rst_n_i) begin
			clk2_sync_q  <= '0;
			gate2_sync_q <= '0;
		end else begin
			clk2_sync_q  <= {clk2_sync_q[1:0], clk2_i};
			gate2_sync_q <= {gate2_sync_q[0], gate2_i};	// kept in step with clk2
		end
	end

	// channels 0 and 1 count every clock
	assign tick = {clk2_sync_q[1] & ~clk2_sync_q[2] & gate2_sync_q[1], 2'b11};

	// register decode
	assign ch     = req_i.adr[5:4];
	assign ofs    = req_i.adr[3:0];
	assign ch_ok  = req_i.adr[7:4] < 4'(NUM_CH);	// no channel 3
	assign wr_stb = req_i.stb & req_i.we & ~ack_q;	// once per cycle

	for (genvar g = 0; g < NUM_CH; g++) begin : g_fire
		assign fire[g] = en_q[g] & tick[g] & armed_q[g] & ~ld_q[g] & (count_q[g] == '0);
	end

	always_ff @(posedge clk_i) begin
		for (int i = 0; i < NUM_CH; i++) begin
			if (wr_stb && ch_ok && ch == 2'(i) && ofs == PIT_RELOAD)
				reload_q[i] <= sel_merge(reload_q[i], req_i.dat, req_i.sel);
		end
	end

	// ========================================================================
	// control, count and output
	// ========================================================================
	always_ff @(posedge clk_i) begin
		if (!rst_n_i) begin
			en_q    <= '0;
			ld_q    <= '0;
			armed_q <= '0;
			out_o   <= '0;
			for (int i = 0; i < NUM_CH; i++) begin
				mode_q[i]  <= PIT_ONESHOT;
				count_q[i] <= '0;
			end
		end else begin
			for (int i = 0; i < NUM_CH; i++) begin
				ld_q[i] <= 1'b0;
				if (wr_stb && ch_ok && ch == 2'(i)) begin
					if (ofs == PIT_RELOAD)
						ld_q[i] <= 1'b1;
					else if (ofs == PIT_CTRL && req_i.sel[0]) begin
						en_q[i]   <= req_i.dat[PIT_CTRL_EN];
						mode_q[i] <= pit_mode_e'(req_i.dat[2:1]);
						ld_q[i]   <= req_i.dat[PIT_CTRL_EN];	// enabling restarts
					end
				end
				if (ld_q[i]) begin
					count_q[i] <= reload_q[i];
					armed_q[i] <= 1'b1;
				end else if (fire[i]) begin
					if (mode_q[i] != PIT_ONESHOT)
						count_q[i] <= reload_q[i];
					else
						armed_q[i] <= 1'b0;	// stays at zero
				end else if (en_q[i] && tick[i] && armed_q[i]) begin
					count_q[i] <= count_q[i] - 32'd1;
				end
				if (fire[i])
					out_o[i] <= (mode_q[i] == PIT_SQUARE) ? ~out_o[i] : 1'b1;
				else if (mode_q[i] != PIT_SQUARE)
					out_o[i] <= 1'b0;	// one clock pulse
			end
		end
	end

	// ========================================================================
	// read mux and ack
	// ========================================================================
	always_comb begin
		rd_dat = '0;
		if (ch_ok) begin
			case (ofs)
				PIT_RELOAD: rd_dat = reload_q[ch];
				PIT_COUNT:  rd_dat = count_q[ch];
				PIT_CTRL:   rd_dat = {29'd0, mode_q[ch], en_q[ch]};
				default:    rd_dat = '0;
			endcase
		end
	end

	always_ff @(posedge clk_i) begin
		if (!rst_n_i)
			ack_q <= 1'b0;
		else
			ack_q <= req_i.stb & ~ack_q;	// drops after one clock
	end

	always_ff @(posedge clk_i)
		dat_q <= rd_dat;

	assign rsp_o.ack = ack_q;
	assign rsp_o.dat = dat_q;

	// a stopped oneshot only restarts through a register write
	for (genvar g = 0; g < NUM_CH; g++) begin : g_oneshot_chk
		a_oneshot_hold: assert property (@(posedge clk_i) disable iff (!rst_n_i)
			(mode_q[g] == PIT_ONESHOT && !ld_q[g] && count_q[g] == '0)
				|=> (count_q[g] == '0));
	end

endmodule

// ==== design/mpu_top.sv ====
`timescale 1ns/1ps

module mpu_top (
	input  logic                              clk_i,
	input  logic                              rst_n_i,
	input  mpu_bus_pkg::bus_req_t             cpu_req_i,
	output mpu_bus_pkg::bus_rsp_t             cpu_rsp_o,
	output mpu_bus_pkg::bus_req_t             ext_req_o,
	input  mpu_bus_pkg::bus_rsp_t             ext_rsp_i,
	input  logic [29:1]                       irq_src_i,	// sources 1 to 29
	input  logic                              pit_clk2_i,
	input  logic                              pit_gate2_i,
	output logic                              pit_out2_o,
	output logic [mpu_irq_pkg::IRQ_W-1:0]     irq_o,
	output logic [mpu_irq_pkg::CAUSE_W-1:0]   cause_o
);
	import mpu_bus_pkg::*;
	import mpu_irq_pkg::*;

	periph_req_t        pit_req;
	periph_rsp_t        pit_rsp;
	periph_req_t        pic_req;
	periph_rsp_t        pic_rsp;
	logic [NUM_CH-1:0]  pit_out;
	logic [NUM_SRC-1:0] irq_src;

	// timer 0 on 31, timer 1 on 30, source 0 held low
	assign irq_src    = {pit_out[0], pit_out[1], irq_src_i, 1'b0};
	assign pit_out2_o = pit_out[2];

	mpu_periph_bus u_bus (
		.clk_i     (clk_i),
		.rst_n_i   (rst_n_i),
		.cpu_req_i (cpu_req_i),
		.cpu_rsp_o (cpu_rsp_o),
		.pit_req_o (pit_req),
		.pit_rsp_i (pit_rsp),
		.pic_req_o (pic_req),
		.pic_rsp_i (pic_rsp),
		.ext_req_o (ext_req_o),
		.ext_rsp_i (ext_rsp_i)
	);

	mpu_pit u_pit (
		.clk_i   (clk_i),
		.rst_n_i (rst_n_i),
		.req_i   (pit_req),
		.rsp_o   (pit_rsp),
		.clk2_i  (pit_clk2_i),
		.gate2_i (pit_gate2_i),
		.out_o   (pit_out)
	);

	mpu_pic u_pic (
		.clk_i   (clk_i),
		.rst_n_i (rst_n_i),
		.req_i   (pic_req),
		.rsp_o   (pic_rsp),
		.src_i   (irq_src),
		.irq_o   (irq_o),
		.cause_o (cause_o)
	);

endmodule

// ==== mpu_top.f ====
design/mpu_bus_pkg.sv
design/mpu_irq_pkg.sv
design/mpu_pit.sv
design/mpu_pic.sv
design/mpu_periph_bus.sv
design/mpu_top.sv
tests/mpu_checker.sv
tests/mpu_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the mpu testbench with verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module mpu_tb -f mpu_top.f \
	--Mdir obj_dir -o Vmpu_tb
if [ $? -ne 0 ]; then
	echo "compile failed"
	exit 1
fi

./obj_dir/Vmpu_tb > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -q "TB FAILED" sim.log; then
	exit 1
fi
if ! grep -q "TB PASSED" sim.log; then
	echo "no pass line in sim.log"
	exit 1
fi
exit 0

// ==== tests/mpu_checker.sv ====
`timescale 1ns/1ps

module mpu_checker (
	input  logic                   clk_i,
	input  logic                   rst_n_i,
	input  mpu_bus_pkg::bus_req_t  cpu_req_i,
	input  mpu_bus_pkg::bus_rsp_t  cpu_rsp_i,
	input  mpu_bus_pkg::bus_req_t  ext_req_i,
	input  mpu_bus_pkg::bus_rsp_t  ext_rsp_i,	// response from the slave model
	input  logic [2:0]             irq_i,
	input  logic [6:0]             cause_i,
	input  logic                   out2_i,
	input  logic                   rd_chk_i,	// read in flight, data expected
	input  logic [63:0]            rd_exp_i,
	input  logic                   irq_chk_i,
	input  logic [16:0]            irq_exp_i,	// {out2, 0, cause, 0, irq}
	output int                     val_errs_o,
	output int                     proto_errs_o
);
	logic cyc_q;
	int   ack_cnt;	// acks seen in the current bus cycle

	initial begin
		val_errs_o   = 0;
		proto_errs_o = 0;
	end

	always @(posedge clk_i) begin
		if (!rst_n_i) begin
			cyc_q   <= 1'b0;
			ack_cnt <= 0;
		end else begin
			cyc_q <= cpu_req_i.cyc;
			if (cpu_rsp_i.ack && !cpu_req_i.cyc) begin
				$display("protocol error at %0t: ack seen outside a bus cycle", $time);
				proto_errs_o++;
			end
			if (cpu_req_i.cyc)
				ack_cnt <= ack_cnt + int'(cpu_rsp_i.ack);
			else if (cyc_q) begin
				if (ack_cnt != 1) begin
					$display("mismatch at %0t: %0d acks in one bus cycle", $time, ack_cnt);
					proto_errs_o++;
				end
				ack_cnt <= 0;
			end
			// read data, both halves for internal slaves
			if (cpu_rsp_i.ack && rd_chk_i && cpu_rsp_i.dat !== rd_exp_i) begin
				$display("mismatch at %0t: read %h expected %h", $time, cpu_rsp_i.dat, rd_exp_i);
				val_errs_o++;
			end
			// error flag comes straight from the external slave
			if (cpu_rsp_i.err !== ext_rsp_i.err) begin
				$display("mismatch at %0t: err %b expected %b", $time, cpu_rsp_i.err,
					ext_rsp_i.err);
				val_errs_o++;
			end
			// whole request copied through while strobed outside
			if (ext_req_i.stb && ext_req_i !== cpu_req_i) begin
				$display("mismatch at %0t: ext request differs from cpu request", $time);
				val_errs_o++;
			end
			if (irq_chk_i && (irq_i !== irq_exp_i[2:0] || cause_i !== irq_exp_i[14:8] ||
				out2_i !== irq_exp_i[16])) begin
				$display("mismatch at %0t: irq %0d cause %0d out2 %b, expected %0d %0d %b",
					$time, irq_i, cause_i, out2_i, irq_exp_i[2:0], irq_exp_i[14:8],
					irq_exp_i[16]);
				val_errs_o++;
			end
		end
	end

endmodule

// ==== tests/mpu_tb.sv ====
`timescale 1ns/1ps

module mpu_tb;
	import mpu_bus_pkg::*;

	localparam int K_WR   = 0;	// bus write
	localparam int K_RD   = 1;	// bus read, compare data
	localparam int K_WAIT = 2;	// set sources and gate, idle or pulse clk2
	localparam int K_IRQ  = 3;	// wait for irq, cause and out2, then compare
	localparam int MAX_ENT = 80;
	localparam logic [31:0] PIT = 32'hFFDC_1100;
	localparam logic [31:0] PIC = 32'hFFDC_0F00;

	logic        clk = 1'b0;
	logic        rst_n;
	bus_req_t    cpu_req;
	bus_rsp_t    cpu_rsp;
	bus_req_t    ext_req;
	bus_rsp_t    ext_rsp;
	logic [29:1] irq_src;
	logic        clk2;
	logic        gate2;
	logic        out2;
	logic [2:0]  irq;
	logic [6:0]  cause;
	logic        rd_chk;
	logic        irq_chk;
	logic [63:0] rd_exp;
	logic [16:0] irq_exp;
	int          val_errs;
	int          proto_errs;
	logic [31:0] lfsr_q = 32'hd9c9647c;
	bit          table_ready = 1'b0;

	// stimulus table
	int          n_ent = 0;
	int          t_kind [MAX_ENT];
	logic [31:0] t_adr [MAX_ENT];
	logic [63:0] t_dat [MAX_ENT];
	int          t_n [MAX_ENT];

	initial begin
		forever #2 clk = ~clk;	// 4 ns period
	end

	mpu_top dut0 (
		.clk_i (clk), .rst_n_i (rst_n),
		.cpu_req_i (cpu_req), .cpu_rsp_o (cpu_rsp),
		.ext_req_o (ext_req), .ext_rsp_i (ext_rsp),
		.irq_src_i (irq_src),
		.pit_clk2_i (clk2), .pit_gate2_i (gate2), .pit_out2_o (out2),
		.irq_o (irq), .cause_o (cause)
	);

	mpu_checker u_chk (
		.clk_i (clk), .rst_n_i (rst_n),
		.cpu_req_i (cpu_req), .cpu_rsp_i (cpu_rsp), .ext_req_i (ext_req),
		.ext_rsp_i (ext_rsp),
		.irq_i (irq), .cause_i (cause), .out2_i (out2),
		.rd_chk_i (rd_chk), .rd_exp_i (rd_exp),
		.irq_chk_i (irq_chk), .irq_exp_i (irq_exp),
		.val_errs_o (val_errs), .proto_errs_o (proto_errs)
	);

	// fibonacci lfsr, taps 32 22 2 1
	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	// external slave data rule
	function automatic logic [63:0] ext_data(input logic [31:0] adr);
		return {adr, adr} ^ 64'hC3C3_5A5A_0FF0_1234;
	endfunction

	// {out2, cause, irq} packed for K_IRQ entries
	function automatic logic [63:0] irq_word(input logic o2, input int c, input int lvl);
		return {47'd0, o2, 1'b0, 7'(c), 5'd0, 3'(lvl)};
	endfunction

	task automatic add_entry(input int kind, input logic [31:0] adr,
		input logic [63:0] dat, input int n);
		t_kind[n_ent] = kind;
		t_adr[n_ent]  = adr;
		t_dat[n_ent]  = dat;
		t_n[n_ent]    = n;
		n_ent++;
	endtask

	task automatic build_table();
		logic [31:0] ea [4];
		ea = '{32'h0000_1000, 32'h8000_0040, 32'hFFDC_1200, 32'h1234_5678};
		// ====================================================================
		// register readback
		// ====================================================================
		add_entry(K_WR, PIT + 'h00, 64'h1234, 0);
		add_entry(K_RD, PIT + 'h00, {2{32'h1234}}, 0);
		add_entry(K_WR, PIT + 'h18, 64'h4, 0);	// ch1 square, disabled
		add_entry(K_RD, PIT + 'h18, {2{32'h4}}, 0);
		add_entry(K_WR, PIC + 'h00, 64'h00F0_0F00, 0);
		add_entry(K_RD, PIC + 'h00, {2{32'h00F0_0F00}}, 0);
		add_entry(K_WR, PIC + 'h04, 64'h0000_FFFF, 0);
		add_entry(K_RD, PIC + 'h04, {2{32'h0000_FFFF}}, 0);
		add_entry(K_WR, PIC + 'h10, 64'h5, 0);
		add_entry(K_RD, PIC + 'h10, {2{32'h5}}, 0);
		for (int i = 0; i < 4; i++)
			add_entry(K_RD, ea[i], ext_data(ea[i]), 0);	// random ack delay
		// edge sources 5 and 20, source 7 disabled
		add_entry(K_WR, PIC + 'h04, 64'h0010_00A0, 0);
		add_entry(K_WR, PIC + 'h00, 64'h0010_0020, 0);
		add_entry(K_WAIT, 32'h0010_0020, 64'h0, 2);
		add_entry(K_WAIT, 32'h0, 64'h0, 2);
		add_entry(K_IRQ, 0, irq_word(0, 20, 5), 8);
		add_entry(K_WR, PIC + 'h0C, 64'd20, 0);
		add_entry(K_IRQ, 0, irq_word(0, 5, 5), 8);
		add_entry(K_WR, PIC + 'h0C, 64'd5, 0);
		add_entry(K_IRQ, 0, irq_word(0, 0, 0), 8);
		add_entry(K_WAIT, 32'h0000_0080, 64'h0, 2);
		add_entry(K_WAIT, 32'h0, 64'h0, 4);
		add_entry(K_IRQ, 0, irq_word(0, 0, 0), 1);
		// ====================================================================
		// timer 0 periodic, reload 20, source 31
		// ====================================================================
		add_entry(K_WR, PIC + 'h04, 64'hC000_0000, 0);
		add_entry(K_WR, PIC + 'h00, 64'h8000_0000, 0);
		add_entry(K_WR, PIT + 'h00, 64'd20, 0);
		add_entry(K_WR, PIT + 'h08, 64'h3, 0);
		add_entry(K_IRQ, 0, irq_word(0, 31, 5), 40);
		add_entry(K_WR, PIC + 'h0C, 64'd31, 0);
		add_entry(K_IRQ, 0, irq_word(0, 0, 0), 1);	// cleared before next pulse
		add_entry(K_IRQ, 0, irq_word(0, 31, 5), 21 + 2 + 4);	// next period
		add_entry(K_WR, PIT + 'h08, 64'h0, 0);
		add_entry(K_WR, PIC + 'h00, 64'h4000_0000, 0);
		// timer 1 oneshot, one pulse on source 30
		add_entry(K_WR, PIT + 'h10, 64'd10, 0);
		add_entry(K_WR, PIT + 'h18, 64'h1, 0);
		add_entry(K_IRQ, 0, irq_word(0, 30, 5), 30);
		add_entry(K_WR, PIC + 'h0C, 64'd30, 0);
		add_entry(K_WAIT, 32'h0, 64'h0, 40);
		add_entry(K_IRQ, 0, irq_word(0, 0, 0), 1);
		add_entry(K_RD, PIT + 'h14, 64'h0, 0);	// count parked at zero
		// timer 2 square on external clock, reload 3
		add_entry(K_WR, PIT + 'h20, 64'd3, 0);
		add_entry(K_WR, PIT + 'h28, 64'h5, 0);
		add_entry(K_WAIT, 32'h0, 64'h3, 4);	// gated, 4 clk2 pulses
		add_entry(K_IRQ, 0, irq_word(1, 0, 0), 8);
		add_entry(K_WAIT, 32'h0, 64'h2, 6);	// gate low, must hold
		add_entry(K_IRQ, 0, irq_word(1, 0, 0), 1);
		add_entry(K_WAIT, 32'h0, 64'h3, 4);
		add_entry(K_IRQ, 0, irq_word(0, 0, 0), 8);
	endtask

	task automatic bus_access(input logic we, input logic [31:0] adr, input logic [63:0] dat);
		@(posedge clk);
		cpu_req.cyc <= 1'b1;
		cpu_req.stb <= 1'b1;
		cpu_req.we  <= we;
		cpu_req.sel <= 8'hFF;
		cpu_req.adr <= adr;
		cpu_req.dat <= we ? dat : 64'd0;
		rd_chk      <= ~we;
		rd_exp      <= dat;
		forever begin
			@(posedge clk);
			if (cpu_rsp.ack)
				break;
		end
		cpu_req.cyc <= 1'b0;
		cpu_req.stb <= 1'b0;
		rd_chk      <= 1'b0;
	endtask

	task automatic run_wait(input int i);
		irq_src <= t_adr[i][29:1];
		gate2   <= t_dat[i][0];
		if (t_dat[i][1]) begin
			repeat (t_n[i]) begin	// one clk2 period is 6 clocks
				@(posedge clk);
				clk2 <= 1'b1;
				repeat (3) @(posedge clk);
				clk2 <= 1'b0;
				repeat (2) @(posedge clk);
			end
		end else begin
			repeat (t_n[i]) @(posedge clk);
		end
	endtask

	task automatic expect_irq(input int i);
		logic [16:0] e;
		e = t_dat[i][16:0];
		for (int k = 0; k < t_n[i]; k++) begin
			@(posedge clk);
			if ({out2, 1'b0, cause, 5'd0, irq} == e)
				break;
		end
		irq_chk <= 1'b1;
		irq_exp <= e;
		@(posedge clk);
		irq_chk <= 1'b0;
	endtask

	// external slave, 0 to 7 cycles of delay
	initial begin
		logic [2:0] dly;
		ext_rsp <= '0;
		forever begin
			@(posedge clk);
			if (ext_req.cyc && ext_req.stb && !ext_rsp.ack) begin
				for (int b = 0; b < 3; b++) begin
					lfsr_q = lfsr_step(lfsr_q);
					dly[b] = lfsr_q[0];
				end
				repeat (dly) @(posedge clk);
				ext_rsp.ack <= 1'b1;
				ext_rsp.dat <= ext_data(ext_req.adr);
				@(posedge clk);
				ext_rsp.ack <= 1'b0;
			end
		end
	end

	initial begin
		wait (table_ready);
		#((n_ent * 64 + 40) * 4);
		$display("timeout: the stimulus table did not finish in time");
		$display("TB FAILED");
		$finish;
	end

	initial begin
		rst_n   <= 1'b0;
		cpu_req <= '0;
		irq_src <= '0;
		clk2    <= 1'b0;
		gate2   <= 1'b0;
		rd_chk  <= 1'b0;
		irq_chk <= 1'b0;
		rd_exp  <= '0;
		irq_exp <= '0;
		build_table();
		table_ready = 1'b1;
		repeat (10) @(posedge clk);
		rst_n <= 1'b1;
		for (int i = 0; i < n_ent; i++) begin
			case (t_kind[i])
				K_WR:    bus_access(1'b1, t_adr[i], t_dat[i]);
				K_RD:    bus_access(1'b0, t_adr[i], t_dat[i]);
				K_WAIT:  run_wait(i);
				default: expect_irq(i);
			endcase
		end
		repeat (4) @(posedge clk);
		$display("errors: value %0d, protocol %0d", val_errs, proto_errs);
		if (val_errs + proto_errs == 0)
			$display("TB PASSED");
		else
			$display("TB FAILED");
		$finish;
	end

endmodule
